/* design/rv_ex_pkg.sv */
// RV32I execute subsystem types
`default_nettype none

package rv_ex_pkg;

  ///////////////////////////////////////////////////////////////////////
  // Widths and constants
  ///////////////////////////////////////////////////////////////////////

  localparam int XLEN   = 32;
  localparam int REG_W  = 5;
  localparam int STRB_W = XLEN / 8;

  // Byte distance to the next sequential instruction
  localparam logic [XLEN-1:0] PC_STEP = 32'd4;

  ///////////////////////////////////////////////////////////////////////
  // Enums
  ///////////////////////////////////////////////////////////////////////

  typedef enum logic [4:0] {
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_SLL,
    OP_SRL,
    OP_SRA,
    OP_SLT,
    OP_SLTU,
    OP_BEQ,
    OP_BNE,
    OP_BLT,
    OP_BGE,
    OP_JAL,
    OP_LW,
    OP_SW
  } ex_op_e;

  typedef enum logic [1:0] {
    LSU_IDLE,
    LSU_ADDR,
    LSU_RESP
  } lsu_state_e;

  ///////////////////////////////////////////////////////////////////////
  // Pipeline structs
  ///////////////////////////////////////////////////////////////////////

  // Decoded instruction from the issue source
  typedef struct packed {
    logic [XLEN-1:0]  pc;
    ex_op_e           op;
    logic [REG_W-1:0] rd;
    logic [REG_W-1:0] rs1;
    logic [REG_W-1:0] rs2;
    logic [XLEN-1:0]  imm;
    logic             use_imm;
  } ex_issue_t;

  // Instruction held in execute, operands resolved
  typedef struct packed {
    logic [XLEN-1:0]  pc;
    ex_op_e           op;
    logic [REG_W-1:0] rd;
    logic [XLEN-1:0]  imm;
    logic             use_imm;
    logic [XLEN-1:0]  opa;
    logic [XLEN-1:0]  opb;
    logic             valid;
  } ex_packet_t;

  typedef struct packed {
    logic [XLEN-1:0]  pc;
    logic [REG_W-1:0] rd;
    logic             we;
    logic [XLEN-1:0]  result;
    logic             redirect;
    logic [XLEN-1:0]  target;
  } ex_retire_t;

endpackage

`default_nettype wire

/* design/rv_regfile.sv */
// Integer register file
`timescale 1ns/1ps
`default_nettype none

module rv_regfile
  import rv_ex_pkg::*;
(
  input  wire              clk_i,
  input  wire              rst_ni,
  input  wire  [REG_W-1:0] rs1_i,
  input  wire  [REG_W-1:0] rs2_i,
  output logic [XLEN-1:0]  rdata1_o,
  output logic [XLEN-1:0]  rdata2_o,
  input  wire              we_i,
  input  wire  [REG_W-1:0] waddr_i,
  input  wire  [XLEN-1:0]  wdata_i
);

  // x0 has no storage
  logic [XLEN-1:0] regs_q [1:31];

  // Write-through so a retiring value reaches the issuing instruction
  function automatic logic [XLEN-1:0] read_port(input logic [REG_W-1:0] addr);
    logic [XLEN-1:0] val;
    if (addr == '0)
      val = '0;
    else if (we_i && (waddr_i == addr))
      val = wdata_i;
    else
      val = regs_q[addr];
    return val;
  endfunction

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      for (int i = 1; i < 32; i++)
        regs_q[i] <= '0;
    end
    else if (we_i && (waddr_i != '0))
    begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  assign rdata1_o = read_port(rs1_i);
  assign rdata2_o = read_port(rs2_i);

endmodule

`default_nettype wire

/* design/rv_operand_stage.sv */
// Operand fetch and bypass stage
`timescale 1ns/1ps
`default_nettype none

module rv_operand_stage
  import rv_ex_pkg::*;
(
  input  wire              clk_i,
  input  wire              rst_ni,

  // Issue handshake
  input  ex_issue_t        issue_i,
  input  wire              issue_valid_i,
  output logic             issue_ready_o,

  input  wire              stall_i,
  input  wire              squash_i,

  // Register file read port
  output logic [REG_W-1:0] rs1_o,
  output logic [REG_W-1:0] rs2_o,
  input  wire  [XLEN-1:0]  rdata1_i,
  input  wire  [XLEN-1:0]  rdata2_i,

  // Bypass from execute
  input  wire              ex_fwd_we_i,
  input  wire  [REG_W-1:0] ex_fwd_rd_i,
  input  wire  [XLEN-1:0]  ex_fwd_data_i,

  output ex_packet_t       ex_pkt_o
);

  logic       transfer;
  logic       fwd_a;
  logic       fwd_b;
  ex_packet_t next_pkt;
  ex_packet_t pkt_q;

  assign issue_ready_o = ~stall_i;
  assign transfer      = issue_valid_i & issue_ready_o;

  assign rs1_o = issue_i.rs1;
  assign rs2_o = issue_i.rs2;

  ///////////////////////////////////////////////////////////////////////
  // Bypass select
  ///////////////////////////////////////////////////////////////////////

  // Execute result wins over the register file, never for x0
  assign fwd_a = ex_fwd_we_i && (ex_fwd_rd_i != '0) && (ex_fwd_rd_i == issue_i.rs1);
  assign fwd_b = ex_fwd_we_i && (ex_fwd_rd_i != '0) && (ex_fwd_rd_i == issue_i.rs2);

  always_comb
  begin
    next_pkt.pc      = issue_i.pc;
    next_pkt.op      = issue_i.op;
    next_pkt.rd      = issue_i.rd;
    next_pkt.imm     = issue_i.imm;
    next_pkt.use_imm = issue_i.use_imm;
    next_pkt.opa     = fwd_a ? ex_fwd_data_i : rdata1_i;
    next_pkt.opb     = fwd_b ? ex_fwd_data_i : rdata2_i;
    // A bubble enters when nothing is accepted
    next_pkt.valid   = transfer & ~squash_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      pkt_q <= '0;
    end
    else if (!stall_i)
    begin
      pkt_q <= next_pkt;
    end
  end

  assign ex_pkt_o = pkt_q;

endmodule

`default_nettype wire

/* design/rv_int_unit.sv */
// Integer and branch unit
`timescale 1ns/1ps
`default_nettype none

module rv_int_unit
  import rv_ex_pkg::*;
(
  input  ex_packet_t      pkt_i,
  output logic [XLEN-1:0] result_o,
  output logic            taken_o,
  output logic [XLEN-1:0] target_o
);

  logic [XLEN-1:0] opa;
  logic [XLEN-1:0] opb;
  logic [4:0]      shamt;
  logic            eq;
  logic            lt;

  assign opa   = pkt_i.opa;
  assign opb   = pkt_i.use_imm ? pkt_i.imm : pkt_i.opb;
  assign shamt = opb[4:0];

  // Branches always compare the two register values
  assign eq = (pkt_i.opa == pkt_i.opb);
  assign lt = ($signed(pkt_i.opa) < $signed(pkt_i.opb));

  assign target_o = pkt_i.pc + pkt_i.imm;

  always_comb
  begin
    result_o = '0;
    taken_o  = 1'b0;
    case (pkt_i.op)
      OP_ADD:  result_o = opa + opb;
      OP_SUB:  result_o = opa - opb;
      OP_AND:  result_o = opa & opb;
      OP_OR:   result_o = opa | opb;
      OP_XOR:  result_o = opa ^ opb;
      OP_SLL:  result_o = opa << shamt;
      OP_SRL:  result_o = opa >> shamt;
      OP_SRA:  result_o = $unsigned($signed(opa) >>> shamt);
      OP_SLT:  result_o = {{(XLEN-1){1'b0}}, $signed(opa) < $signed(opb)};
      OP_SLTU: result_o = {{(XLEN-1){1'b0}}, opa < opb};
      OP_BEQ:  taken_o  = eq;
      OP_BNE:  taken_o  = ~eq;
      OP_BLT:  taken_o  = lt;
      OP_BGE:  taken_o  = ~lt;
      OP_JAL:
      begin
        // Link address
        result_o = pkt_i.pc + PC_STEP;
        taken_o  = 1'b1;
      end
      default: result_o = '0;
    endcase
  end

endmodule

`default_nettype wire

/* design/rv_lsu.sv */
// Load-store unit with AXI4-Lite master
`timescale 1ns/1ps
`default_nettype none

module rv_lsu
  import rv_ex_pkg::*;
#(
  parameter int AXI_ADDR_W = 16
)
(
  input  wire                   clk_i,
  input  wire                   rst_ni,
  input  ex_packet_t            pkt_i,
  output logic [XLEN-1:0]       load_data_o,
  output logic                  done_o,
  output logic                  stall_o,

  // AXI4-Lite master
  output logic [AXI_ADDR_W-1:0] m_awaddr_o,
  output logic                  m_awvalid_o,
  input  wire                   m_awready_i,
  output logic [XLEN-1:0]       m_wdata_o,
  output logic [STRB_W-1:0]     m_wstrb_o,
  output logic                  m_wvalid_o,
  input  wire                   m_wready_i,
  input  wire                   m_bvalid_i,
  output logic                  m_bready_o,
  output logic [AXI_ADDR_W-1:0] m_araddr_o,
  output logic                  m_arvalid_o,
  input  wire                   m_arready_i,
  input  wire  [XLEN-1:0]       m_rdata_i,
  input  wire                   m_rvalid_i,
  output logic                  m_rready_o
);

  lsu_state_e      state_q;
  logic            is_load;
  logic            is_store;
  logic [XLEN-1:0] addr;
  logic            aw_pend;
  logic            w_pend;
  logic            ar_pend;

  assign is_load  = pkt_i.valid && (pkt_i.op == OP_LW);
  assign is_store = pkt_i.valid && (pkt_i.op == OP_SW);

  // Packet is held by the stall, so the payload stays stable
  assign addr       = pkt_i.opa + pkt_i.imm;
  assign m_awaddr_o = addr[AXI_ADDR_W-1:0];
  assign m_araddr_o = addr[AXI_ADDR_W-1:0];
  assign m_wdata_o  = pkt_i.opb;
  assign m_wstrb_o  = '1;

  // Request channels still waiting after this edge
  assign aw_pend = m_awvalid_o & ~m_awready_i;
  assign w_pend  = m_wvalid_o & ~m_wready_i;
  assign ar_pend = m_arvalid_o & ~m_arready_i;

  assign m_bready_o = (state_q == LSU_RESP) & is_store;
  assign m_rready_o = (state_q == LSU_RESP) & is_load;

  assign done_o      = (m_bready_o & m_bvalid_i) | (m_rready_o & m_rvalid_i);
  assign stall_o     = (is_load | is_store) & ~done_o;
  assign load_data_o = m_rdata_i;

  ///////////////////////////////////////////////////////////////////////
  // Transaction FSM
  ///////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state_q     <= LSU_IDLE;
      m_awvalid_o <= 1'b0;
      m_wvalid_o  <= 1'b0;
      m_arvalid_o <= 1'b0;
    end
    else
    begin
      unique case (state_q)
        LSU_IDLE:
        begin
          if (is_load | is_store)
          begin
            m_arvalid_o <= is_load;
            m_awvalid_o <= is_store;
            m_wvalid_o  <= is_store;
            state_q     <= LSU_ADDR;
          end
        end
        LSU_ADDR:
        begin
          // AW and W drop on their own handshakes
          m_awvalid_o <= aw_pend;
          m_wvalid_o  <= w_pend;
          m_arvalid_o <= ar_pend;
          if (!(aw_pend | w_pend | ar_pend))
            state_q <= LSU_RESP;
        end
        LSU_RESP:
        begin
          if (done_o)
            state_q <= LSU_IDLE;
        end
        default: state_q <= LSU_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

/* design/rv_ex_stage.sv */
// Execute stage and retire register
`timescale 1ns/1ps
`default_nettype none

module rv_ex_stage
  import rv_ex_pkg::*;
#(
  parameter int AXI_ADDR_W = 16
)
(
  input  wire                   clk_i,
  input  wire                   rst_ni,
  input  ex_packet_t            pkt_i,
  output logic                  stall_o,
  output logic                  squash_o,

  // Bypass to operand stage
  output logic                  fwd_we_o,
  output logic [REG_W-1:0]      fwd_rd_o,
  output logic [XLEN-1:0]       fwd_data_o,

  output ex_retire_t            retire_o,
  output logic                  retire_valid_o,

  // AXI4-Lite master
  output logic [AXI_ADDR_W-1:0] m_awaddr_o,
  output logic                  m_awvalid_o,
  input  wire                   m_awready_i,
  output logic [XLEN-1:0]       m_wdata_o,
  output logic [STRB_W-1:0]     m_wstrb_o,
  output logic                  m_wvalid_o,
  input  wire                   m_wready_i,
  input  wire                   m_bvalid_i,
  output logic                  m_bready_o,
  output logic [AXI_ADDR_W-1:0] m_araddr_o,
  output logic                  m_arvalid_o,
  input  wire                   m_arready_i,
  input  wire  [XLEN-1:0]       m_rdata_i,
  input  wire                   m_rvalid_i,
  output logic                  m_rready_o
);

  logic [XLEN-1:0] int_result;
  logic            taken;
  logic [XLEN-1:0] target;
  logic [XLEN-1:0] load_data;
  logic            lsu_done;
  logic            is_mem;
  logic            writes_rd;
  logic            complete;
  logic [XLEN-1:0] result;
  ex_retire_t      next_retire;

  rv_int_unit u_int_unit (
    .pkt_i    ( pkt_i      ),
    .result_o ( int_result ),
    .taken_o  ( taken      ),
    .target_o ( target     )
  );

  rv_lsu #(
    .AXI_ADDR_W ( AXI_ADDR_W )
  ) u_lsu (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .pkt_i       ( pkt_i       ),
    .load_data_o ( load_data   ),
    .done_o      ( lsu_done    ),
    .stall_o     ( stall_o     ),
    .m_awaddr_o  ( m_awaddr_o  ),
    .m_awvalid_o ( m_awvalid_o ),
    .m_awready_i ( m_awready_i ),
    .m_wdata_o   ( m_wdata_o   ),
    .m_wstrb_o   ( m_wstrb_o   ),
    .m_wvalid_o  ( m_wvalid_o  ),
    .m_wready_i  ( m_wready_i  ),
    .m_bvalid_i  ( m_bvalid_i  ),
    .m_bready_o  ( m_bready_o  ),
    .m_araddr_o  ( m_araddr_o  ),
    .m_arvalid_o ( m_arvalid_o ),
    .m_arready_i ( m_arready_i ),
    .m_rdata_i   ( m_rdata_i   ),
    .m_rvalid_i  ( m_rvalid_i  ),
    .m_rready_o  ( m_rready_o  )
  );

  assign is_mem = (pkt_i.op == OP_LW) || (pkt_i.op == OP_SW);

  always_comb
  begin
    case (pkt_i.op)
      OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_SW: writes_rd = 1'b0;
      default:                               writes_rd = 1'b1;
    endcase
  end

  assign result   = (pkt_i.op == OP_LW) ? load_data : int_result;
  assign complete = pkt_i.valid & (is_mem ? lsu_done : 1'b1);
  assign squash_o = pkt_i.valid & taken;

  assign fwd_we_o   = pkt_i.valid & writes_rd;
  assign fwd_rd_o   = pkt_i.rd;
  assign fwd_data_o = result;

  ///////////////////////////////////////////////////////////////////////
  // Retire register
  ///////////////////////////////////////////////////////////////////////

  always_comb
  begin
    next_retire.pc       = pkt_i.pc;
    next_retire.rd       = pkt_i.rd;
    next_retire.we       = writes_rd;
    next_retire.result   = result;
    next_retire.redirect = taken;
    next_retire.target   = target;
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      retire_valid_o <= 1'b0;
      retire_o       <= '0;
    end
    else
    begin
      retire_valid_o <= complete;
      if (complete)
        retire_o <= next_retire;
    end
  end

endmodule

`default_nettype wire

/* design/rv_ex_top.sv */
// RV32I execute subsystem top
`timescale 1ns/1ps
`default_nettype none

module rv_ex_top
  import rv_ex_pkg::*;
#(
  parameter int AXI_ADDR_W = 16
)
(
  input  wire                   clk_i,
  input  wire                   rst_ni,

  input  ex_issue_t             issue_i,
  input  wire                   issue_valid_i,
  output logic                  issue_ready_o,

  output ex_retire_t            retire_o,
  output logic                  retire_valid_o,

  // AXI4-Lite master
  output logic [AXI_ADDR_W-1:0] m_awaddr_o,
  output logic                  m_awvalid_o,
  input  wire                   m_awready_i,
  output logic [XLEN-1:0]       m_wdata_o,
  output logic [STRB_W-1:0]     m_wstrb_o,
  output logic                  m_wvalid_o,
  input  wire                   m_wready_i,
  input  wire                   m_bvalid_i,
  output logic                  m_bready_o,
  output logic [AXI_ADDR_W-1:0] m_araddr_o,
  output logic                  m_arvalid_o,
  input  wire                   m_arready_i,
  input  wire  [XLEN-1:0]       m_rdata_i,
  input  wire                   m_rvalid_i,
  output logic                  m_rready_o
);

  logic [REG_W-1:0] rs1;
  logic [REG_W-1:0] rs2;
  logic [XLEN-1:0]  rdata1;
  logic [XLEN-1:0]  rdata2;
  ex_packet_t       ex_pkt;
  logic             stall;
  logic             squash;
  logic             fwd_we;
  logic [REG_W-1:0] fwd_rd;
  logic [XLEN-1:0]  fwd_data;

  // Write port fed straight from the retire register
  rv_regfile u_regfile (
    .clk_i    ( clk_i                         ),
    .rst_ni   ( rst_ni                        ),
    .rs1_i    ( rs1                           ),
    .rs2_i    ( rs2                           ),
    .rdata1_o ( rdata1                        ),
    .rdata2_o ( rdata2                        ),
    .we_i     ( retire_valid_o & retire_o.we  ),
    .waddr_i  ( retire_o.rd                   ),
    .wdata_i  ( retire_o.result               )
  );

  rv_operand_stage u_operand_stage (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .issue_i       ( issue_i       ),
    .issue_valid_i ( issue_valid_i ),
    .issue_ready_o ( issue_ready_o ),
    .stall_i       ( stall         ),
    .squash_i      ( squash        ),
    .rs1_o         ( rs1           ),
    .rs2_o         ( rs2           ),
    .rdata1_i      ( rdata1        ),
    .rdata2_i      ( rdata2        ),
    .ex_fwd_we_i   ( fwd_we        ),
    .ex_fwd_rd_i   ( fwd_rd        ),
    .ex_fwd_data_i ( fwd_data      ),
    .ex_pkt_o      ( ex_pkt        )
  );

  rv_ex_stage #(
    .AXI_ADDR_W ( AXI_ADDR_W )
  ) u_ex_stage (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .pkt_i          ( ex_pkt         ),
    .stall_o        ( stall          ),
    .squash_o       ( squash         ),
    .fwd_we_o       ( fwd_we         ),
    .fwd_rd_o       ( fwd_rd         ),
    .fwd_data_o     ( fwd_data       ),
    .retire_o       ( retire_o       ),
    .retire_valid_o ( retire_valid_o ),
    .m_awaddr_o     ( m_awaddr_o     ),
    .m_awvalid_o    ( m_awvalid_o    ),
    .m_awready_i    ( m_awready_i    ),
    .m_wdata_o      ( m_wdata_o      ),
    .m_wstrb_o      ( m_wstrb_o      ),
    .m_wvalid_o     ( m_wvalid_o     ),
    .m_wready_i     ( m_wready_i     ),
    .m_bvalid_i     ( m_bvalid_i     ),
    .m_bready_o     ( m_bready_o     ),
    .m_araddr_o     ( m_araddr_o     ),
    .m_arvalid_o    ( m_arvalid_o    ),
    .m_arready_i    ( m_arready_i    ),
    .m_rdata_i      ( m_rdata_i      ),
    .m_rvalid_i     ( m_rvalid_i     ),
    .m_rready_o     ( m_rready_o     )
  );

endmodule

`default_nettype wire

/* tests/tb_rv_ex_top.sv */
// RV32I execute subsystem testbench
`timescale 1ns/1ps
`default_nettype none

module tb_rv_ex_top
  import rv_ex_pkg::*;
();

  localparam int          AXI_ADDR_W     = 16;
  localparam int          MEM_WORDS      = 256;
  localparam int          TIMEOUT_CYCLES = 200;
  localparam logic [31:0] LFSR_SEED      = 32'd84344;
  localparam logic [31:0] LFSR_MASK      = 32'hD0000001;

  typedef struct packed {
    logic                  store;
    logic [AXI_ADDR_W-1:0] addr;
  } mem_req_t;

  logic                  clk_i;
  logic                  rst_ni;
  ex_issue_t             issue_i;
  logic                  issue_valid_i;
  logic                  issue_ready_o;
  ex_retire_t            retire_o;
  logic                  retire_valid_o;
  logic [AXI_ADDR_W-1:0] m_awaddr_o;
  logic                  m_awvalid_o;
  logic                  m_awready_i;
  logic [XLEN-1:0]       m_wdata_o;
  logic [STRB_W-1:0]     m_wstrb_o;
  logic                  m_wvalid_o;
  logic                  m_wready_i;
  logic                  m_bvalid_i;
  logic                  m_bready_o;
  logic [AXI_ADDR_W-1:0] m_araddr_o;
  logic                  m_arvalid_o;
  logic                  m_arready_i;
  logic [XLEN-1:0]       m_rdata_i;
  logic                  m_rvalid_i;
  logic                  m_rready_o;

  // Model state, stimulus state and expectation queues
  logic [31:0] lfsr_q      = LFSR_SEED;
  logic [31:0] pc_q        = 32'h0000_1000;
  int          edge_cnt    = 0;
  int          squash_edge = -1;
  logic [31:0] model_regs [32];
  logic [31:0] ref_mem [MEM_WORDS];
  logic [31:0] slave_mem [MEM_WORDS];
  ex_retire_t  retire_q [$];
  int          edge_q [$];
  mem_req_t    mem_exp_q [$];
  ex_retire_t  cmp_exp;
  int          cmp_edge;

  // Slave channel state
  int                    ar_dly;
  int                    aw_dly;
  int                    w_dly;
  int                    r_dly;
  int                    b_dly;
  logic                  r_pend;
  logic                  b_pend;
  logic                  aw_got;
  logic                  w_got;
  logic [AXI_ADDR_W-1:0] wr_addr;
  logic [31:0]           wr_data;

  rv_ex_top #(
    .AXI_ADDR_W ( AXI_ADDR_W )
  ) u_rv_ex_top (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .issue_i        ( issue_i        ),
    .issue_valid_i  ( issue_valid_i  ),
    .issue_ready_o  ( issue_ready_o  ),
    .retire_o       ( retire_o       ),
    .retire_valid_o ( retire_valid_o ),
    .m_awaddr_o     ( m_awaddr_o     ),
    .m_awvalid_o    ( m_awvalid_o    ),
    .m_awready_i    ( m_awready_i    ),
    .m_wdata_o      ( m_wdata_o      ),
    .m_wstrb_o      ( m_wstrb_o      ),
    .m_wvalid_o     ( m_wvalid_o     ),
    .m_wready_i     ( m_wready_i     ),
    .m_bvalid_i     ( m_bvalid_i     ),
    .m_bready_o     ( m_bready_o     ),
    .m_araddr_o     ( m_araddr_o     ),
    .m_arvalid_o    ( m_arvalid_o    ),
    .m_arready_i    ( m_arready_i    ),
    .m_rdata_i      ( m_rdata_i      ),
    .m_rvalid_i     ( m_rvalid_i     ),
    .m_rready_o     ( m_rready_o     )
  );

  initial
  begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  always @(posedge clk_i)
    edge_cnt <= edge_cnt + 1;

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  task automatic stop_run(input string why);
    $display("%0t: %s", $time, why);
    $display("LSU state encoding is %0d bits wide", $bits(lsu_state_e));
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp)
    else
    begin
      $display("error %0t %s: got %h, expected %h", $time, name, got, exp);
      $display("Verification failed");
      $fatal(1);
    end
  endtask

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        out_bit;
    val = '0;
    for (int k = 0; k < n; k++)
    begin
      out_bit = lfsr_q[0];
      lfsr_q  = (lfsr_q >> 1) ^ (out_bit ? LFSR_MASK : 32'h0);
      val     = {val[30:0], out_bit};
    end
    return val;
  endfunction

  function automatic logic [31:0] fill_word(input int idx);
    return (32'(idx) * 32'h9E3779B1) ^ 32'h13579BDF;
  endfunction

  function automatic ex_op_e pick_op(input int first, input int count);
    int r;
    r = int'(rand_bits(5)) % count;
    return ex_op_e'(5'(first + r));
  endfunction

  // Registers x0..x3 only, so dependencies and x0 come up often
  function automatic ex_issue_t make_instr(input ex_op_e op, input int addr_bits);
    ex_issue_t ins;
    ins.pc      = pc_q;
    ins.op      = op;
    ins.rd      = REG_W'(rand_bits(2));
    ins.rs1     = REG_W'(rand_bits(2));
    ins.rs2     = REG_W'(rand_bits(2));
    ins.use_imm = 1'(rand_bits(1));
    ins.imm     = 32'($signed(12'(rand_bits(12))));
    if (op == OP_LW || op == OP_SW)
    begin
      // Word aligned, inside the slave array
      ins.rs1     = '0;
      ins.use_imm = 1'b1;
      ins.imm     = 32'({8'(rand_bits(addr_bits)), 2'b00});
    end
    else if (op >= OP_BEQ)
    begin
      ins.use_imm = 1'b0;
      ins.imm     = 32'($signed({10'(rand_bits(10)), 2'b00}));
    end
    pc_q = pc_q + 32'd4;
    return ins;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  function automatic ex_retire_t expected_retire(input ex_issue_t ins);
    ex_retire_t  r;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] bb;
    logic [7:0]  widx;
    a  = model_regs[ins.rs1];
    b  = model_regs[ins.rs2];
    bb = ins.use_imm ? ins.imm : b;
    widx       = 8'((a + ins.imm) >> 2);
    r.pc       = ins.pc;
    r.rd       = ins.rd;
    r.we       = 1'b1;
    r.result   = '0;
    r.redirect = 1'b0;
    r.target   = ins.pc + ins.imm;
    case (ins.op)
      OP_ADD:  r.result = a + bb;
      OP_SUB:  r.result = a - bb;
      OP_AND:  r.result = a & bb;
      OP_OR:   r.result = a | bb;
      OP_XOR:  r.result = a ^ bb;
      OP_SLL:  r.result = a << bb[4:0];
      OP_SRL:  r.result = a >> bb[4:0];
      OP_SRA:  r.result = 32'($signed(a) >>> bb[4:0]);
      OP_SLT:  r.result = 32'($signed(a) < $signed(bb));
      OP_SLTU: r.result = 32'(a < bb);
      OP_BEQ:  {r.we, r.redirect} = {1'b0, a == b};
      OP_BNE:  {r.we, r.redirect} = {1'b0, a != b};
      OP_BLT:  {r.we, r.redirect} = {1'b0, $signed(a) < $signed(b)};
      OP_BGE:  {r.we, r.redirect} = {1'b0, $signed(a) >= $signed(b)};
      OP_JAL:  {r.redirect, r.result} = {1'b1, ins.pc + 32'd4};
      OP_LW:   r.result = ref_mem[widx];
      OP_SW:
      begin
        r.we          = 1'b0;
        ref_mem[widx] = b;
      end
      default: r.result = '0;
    endcase
    if (r.we && ins.rd != '0)
      model_regs[ins.rd] = r.result;
    return r;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Issue driver
  //////////////////////////////////////////////////////////////////////

  task automatic send_instr(input ex_issue_t ins);
    int         waited;
    int         acc_edge;
    mem_req_t   req;
    ex_retire_t exp;
    issue_i       = ins;
    issue_valid_i = 1'b1;
    waited        = 0;
    #1;
    while (!issue_ready_o)
    begin
      waited++;
      assert (waited < TIMEOUT_CYCLES)
      else stop_run("issue_ready_o stayed low, instruction never accepted");
      @(negedge clk_i);
      #1;
    end
    acc_edge = edge_cnt + 1;
    // Accepted right after a taken branch or JAL means squashed
    if (acc_edge != squash_edge)
    begin
      if (ins.op == OP_LW || ins.op == OP_SW)
      begin
        req.store = (ins.op == OP_SW);
        req.addr  = AXI_ADDR_W'(model_regs[ins.rs1] + ins.imm);
        mem_exp_q.push_back(req);
        edge_q.push_back(-1);
      end
      else
      begin
        edge_q.push_back(acc_edge + 1);
      end
      exp = expected_retire(ins);
      retire_q.push_back(exp);
      if (exp.redirect)
        squash_edge = acc_edge + 1;
    end
    @(negedge clk_i);
    issue_valid_i = 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    issue_valid_i = 1'b0;
    repeat (n) @(negedge clk_i);
  endtask

  //////////////////////////////////////////////////////////////////////
  // AXI4-Lite slave model
  //////////////////////////////////////////////////////////////////////

  task automatic check_request(input logic store, input logic [AXI_ADDR_W-1:0] addr);
    mem_req_t req;
    assert (mem_exp_q.size() > 0)
    else stop_run("AXI request seen with no LW or SW in execute");
    req = mem_exp_q.pop_front();
    check_value("AXI request is store", 32'(store), 32'(req.store));
    check_value(store ? "m_awaddr_o" : "m_araddr_o", 32'(addr), 32'(req.addr));
  endtask

  // Handshakes are decided at the falling edge and complete at the next rising edge
  initial
  begin
    m_awready_i = 1'b0;
    m_wready_i  = 1'b0;
    m_bvalid_i  = 1'b0;
    m_arready_i = 1'b0;
    m_rvalid_i  = 1'b0;
    m_rdata_i   = '0;
    r_pend      = 1'b0;
    b_pend      = 1'b0;
    aw_got      = 1'b0;
    w_got       = 1'b0;
    for (int k = 0; k < MEM_WORDS; k++)
      slave_mem[k] = fill_word(k);
    forever
    begin
      @(negedge clk_i);
      if (rst_ni)
      begin
        m_rvalid_i = r_pend && (r_dly == 0);
        if (r_pend && r_dly > 0)
          r_dly--;
        if (m_rvalid_i && m_rready_o)
          r_pend = 1'b0;
        m_bvalid_i = b_pend && (b_dly == 0);
        if (b_pend && b_dly > 0)
          b_dly--;
        if (m_bvalid_i && m_bready_o)
          b_pend = 1'b0;

        m_arready_i = m_arvalid_o && (ar_dly == 0);
        m_awready_i = m_awvalid_o && (aw_dly == 0);
        m_wready_i  = m_wvalid_o && (w_dly == 0);
        if (m_arvalid_o && ar_dly > 0)
          ar_dly--;
        if (m_awvalid_o && aw_dly > 0)
          aw_dly--;
        if (m_wvalid_o && w_dly > 0)
          w_dly--;
        if (m_arvalid_o && m_arready_i)
        begin
          check_request(1'b0, m_araddr_o);
          m_rdata_i = slave_mem[m_araddr_o[9:2]];
          r_pend    = 1'b1;
          r_dly     = int'(rand_bits(2));
          ar_dly    = int'(rand_bits(2));
        end
        if (m_awvalid_o && m_awready_i)
        begin
          check_request(1'b1, m_awaddr_o);
          wr_addr = m_awaddr_o;
          aw_got  = 1'b1;
          aw_dly  = int'(rand_bits(2));
        end
        if (m_wvalid_o && m_wready_i)
        begin
          check_value("m_wstrb_o", 32'(m_wstrb_o), 32'hF);
          wr_data = m_wdata_o;
          w_got   = 1'b1;
          w_dly   = int'(rand_bits(2));
        end
        if (aw_got && w_got)
        begin
          slave_mem[wr_addr[9:2]] = wr_data;
          {aw_got, w_got} = 2'b00;
          b_pend = 1'b1;
          b_dly  = int'(rand_bits(2));
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Retire comparator and stall monitor
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk_i)
  begin
    if (rst_ni && retire_valid_o)
    begin
      assert (retire_q.size() > 0)
      else stop_run("retire_valid_o high with no instruction outstanding");
      cmp_exp  = retire_q.pop_front();
      cmp_edge = edge_q.pop_front();
      check_value("retire_o.pc", retire_o.pc, cmp_exp.pc);
      check_value("retire_o.rd", 32'(retire_o.rd), 32'(cmp_exp.rd));
      check_value("retire_o.we", 32'(retire_o.we), 32'(cmp_exp.we));
      check_value("retire_o.redirect", 32'(retire_o.redirect), 32'(cmp_exp.redirect));
      if (cmp_exp.we)
        check_value("retire_o.result", retire_o.result, cmp_exp.result);
      if (cmp_exp.redirect)
        check_value("retire_o.target", retire_o.target, cmp_exp.target);
      // One cycle from accept to retire when nothing stalls
      if (cmp_edge >= 0)
        check_value("retire edge", 32'(edge_cnt), 32'(cmp_edge));
    end
  end

  always @(negedge clk_i)
  begin
    #2;
    if (rst_ni && (m_arvalid_o || m_awvalid_o || m_wvalid_o ||
                   (m_rready_o && !m_rvalid_i) || (m_bready_o && !m_bvalid_i)))
    begin
      assert (!issue_ready_o)
      else stop_run("issue_ready_o high while a memory access is outstanding");
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    int waited;
    rst_ni        = 1'b0;
    issue_valid_i = 1'b0;
    issue_i       = '0;
    for (int k = 0; k < 32; k++)
      model_regs[k] = '0;
    for (int k = 0; k < MEM_WORDS; k++)
      ref_mem[k] = fill_word(k);
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);

    // Reset values
    check_value("retire_valid_o", 32'(retire_valid_o), 32'd0);
    check_value("m_awvalid_o", 32'(m_awvalid_o), 32'd0);
    check_value("m_wvalid_o", 32'(m_wvalid_o), 32'd0);
    check_value("m_arvalid_o", 32'(m_arvalid_o), 32'd0);
    check_value("m_bready_o", 32'(m_bready_o), 32'd0);
    check_value("m_rready_o", 32'(m_rready_o), 32'd0);
    check_value("issue_ready_o", 32'(issue_ready_o), 32'd1);

    // Dependent ALU stream
    for (int i = 0; i < 200; i++)
      send_instr(make_instr(pick_op(int'(OP_ADD), 10), 8));

    // Stores and loads over a few words, with some ALU in between
    for (int i = 0; i < 150; i++)
    begin
      if (rand_bits(2) == 32'd0)
        send_instr(make_instr(OP_ADD, 3));
      else
        send_instr(make_instr(rand_bits(1) != 0 ? OP_SW : OP_LW, 3));
    end

    // All opcodes with random idle gaps
    for (int i = 0; i < 200; i++)
    begin
      send_instr(make_instr(pick_op(int'(OP_ADD), 17), 8));
      if (rand_bits(2) == 32'd0)
        idle_cycles(int'(rand_bits(1)) + 1);
    end

    // Branch or JAL followed by any instruction
    for (int i = 0; i < 200; i++)
    begin
      if (i % 2 == 0)
        send_instr(make_instr(pick_op(int'(OP_BEQ), 5), 8));
      else
        send_instr(make_instr(pick_op(int'(OP_ADD), 17), 8));
    end

    waited = 0;
    while (retire_q.size() != 0 || mem_exp_q.size() != 0)
    begin
      waited++;
      assert (waited < TIMEOUT_CYCLES)
      else stop_run("outstanding instructions never retired");
      @(negedge clk_i);
    end
    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
design/rv_ex_pkg.sv
design/rv_regfile.sv
design/rv_operand_stage.sv
design/rv_int_unit.sv
design/rv_lsu.sv
design/rv_ex_stage.sv
design/rv_ex_top.sv
tests/tb_rv_ex_top.sv

/* run.sh */
#!/bin/sh
# Build and run the execute subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f verilog.f --top-module tb_rv_ex_top -Mdir obj_dir

./obj_dir/Vtb_rv_ex_top
